/* src/lbp_pkg.sv */
package lbp_pkg;

  // Neighbours of a 3x3 window
  localparam int NUM_NBR = 8;

  // riu2 codes 0..9
  localparam int NUM_BINS = 10;

  // Bit k set when neighbour k >= centre
  // Neighbour 0 is top left, order runs clockwise
  typedef logic [NUM_NBR-1:0] pattern_t;

  typedef logic [3:0] code_t;

  typedef logic [31:0] bin_cnt_t;

  // Patterns with more than two circular transitions
  localparam code_t NONUNIFORM_CODE = code_t'(9);

  // Transition limit for a uniform pattern
  localparam int MAX_UNIFORM_TRANS = 2;

endpackage

/* src/apb_pkg.sv */
package apb_pkg;

  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Register map
  localparam apb_addr_t ADDR_CTRL     = 12'h000;
  localparam apb_addr_t ADDR_STATUS   = 12'h004;
  localparam apb_addr_t ADDR_FRAMES   = 12'h008;
  localparam apb_addr_t ADDR_BIN_BASE = 12'h040; // Bin k at base + 4*k

  // CTRL fields
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;  // Self-clearing

  // STATUS fields, write 1 to clear
  localparam int STATUS_FRAME_DONE_BIT = 0;

endpackage

/* src/lbp_threshold.sv */
`timescale 1ns/1ps

module lbp_threshold #(
  parameter int PIX_W = 8
) (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             enable_i,
  input  logic                             win_valid_i,
  input  logic                             win_last_i,
  input  logic [PIX_W-1:0]                 center_i,
  input  logic [lbp_pkg::NUM_NBR*PIX_W-1:0] nbr_i,
  output lbp_pkg::pattern_t                pattern_o,
  output logic                             done_o,
  output logic                             progress_done_o
);

  lbp_pkg::pattern_t cmp;
  lbp_pkg::pattern_t pattern_q;
  logic              accept;
  logic              done_q;
  logic              last_q;

  // Window taken only while enabled
  assign accept = win_valid_i & enable_i;

  // Unsigned neighbour >= centre
  always_comb begin
    for (int k = 0; k < lbp_pkg::NUM_NBR; k++) begin
      cmp[k] = (nbr_i[k*PIX_W +: PIX_W] >= center_i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      done_q <= accept;
      last_q <= accept & win_last_i;  // Dropped windows lose their last flag too
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pattern_q <= cmp;
    end
  end

  assign pattern_o       = pattern_q;
  assign done_o          = done_q;
  assign progress_done_o = last_q;

endmodule

/* src/riu2_mapping.sv */
`timescale 1ns/1ps

module riu2_mapping (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              done_i,
  input  logic              progress_done_i,
  input  lbp_pkg::pattern_t pattern_i,
  output lbp_pkg::code_t    data_o,
  output logic              done_o,
  output logic              progress_done_o
);

  lbp_pkg::pattern_t trans;

  // Stage 1: pair sums
  logic [1:0] tr_s1 [4];
  logic [1:0] pop_s1 [4];
  logic       st1_done;

  // Stage 2: partial sums
  logic [2:0] tr_s2 [2];
  logic [2:0] pop_s2 [2];
  logic       st2_done;

  // Stage 3: full counts
  logic [3:0] tr_cnt;
  logic [3:0] pop_cnt;
  logic       st3_done;

  logic [2:0] prog_sr;

  // Circular neighbour transitions, bit 7 wraps to bit 0
  always_comb begin
    for (int k = 0; k < lbp_pkg::NUM_NBR; k++) begin
      trans[k] = pattern_i[k] ^ pattern_i[(k + 1) % lbp_pkg::NUM_NBR];
    end
  end

  // Stage valid chain
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      st1_done <= 1'b0;
      st2_done <= 1'b0;
      st3_done <= 1'b0;
    end else begin
      st1_done <= done_i;
      st2_done <= st1_done;
      st3_done <= st2_done;
    end
  end

  always_ff @(posedge clk) begin
    if (done_i) begin
      for (int i = 0; i < 4; i++) begin
        tr_s1[i]  <= {1'b0, trans[2*i]} + {1'b0, trans[2*i+1]};
        pop_s1[i] <= {1'b0, pattern_i[2*i]} + {1'b0, pattern_i[2*i+1]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (st1_done) begin
      for (int i = 0; i < 2; i++) begin
        tr_s2[i]  <= {1'b0, tr_s1[2*i]} + {1'b0, tr_s1[2*i+1]};
        pop_s2[i] <= {1'b0, pop_s1[2*i]} + {1'b0, pop_s1[2*i+1]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (st2_done) begin
      tr_cnt  <= {1'b0, tr_s2[0]} + {1'b0, tr_s2[1]};
      pop_cnt <= {1'b0, pop_s2[0]} + {1'b0, pop_s2[1]};
    end
  end

  // Progress flag rides alongside the three stages
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      prog_sr <= '0;
    end else begin
      prog_sr <= {prog_sr[1:0], progress_done_i};
    end
  end

  // Non-uniform patterns collapse to one code
  assign data_o = (tr_cnt > lbp_pkg::MAX_UNIFORM_TRANS) ? lbp_pkg::NONUNIFORM_CODE
                                                        : lbp_pkg::code_t'(pop_cnt);

  assign done_o          = st3_done;
  assign progress_done_o = prog_sr[2];

endmodule

/* src/lbp_histogram.sv */
`timescale 1ns/1ps

module lbp_histogram #(
  parameter int CNT_W = 32
) (
  input  logic                                         clk,
  input  logic                                         rst_n_i,
  input  logic                                         clear_i,
  input  logic                                         done_i,
  input  logic                                         progress_done_i,
  input  lbp_pkg::code_t                               code_i,
  output lbp_pkg::bin_cnt_t [lbp_pkg::NUM_BINS-1:0]    bins_o,
  output lbp_pkg::bin_cnt_t                            frames_o,
  output logic                                         frame_done_o
);

  logic [CNT_W-1:0] bin_q [lbp_pkg::NUM_BINS];
  logic [CNT_W-1:0] frame_q;
  logic             frame_done_q;
  logic             frame_end;

  // Last code of a frame
  assign frame_end = done_i & progress_done_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int k = 0; k < lbp_pkg::NUM_BINS; k++) begin
        bin_q[k] <= '0;
      end
    end else if (clear_i) begin
      // A code landing with the clear still counts
      for (int k = 0; k < lbp_pkg::NUM_BINS; k++) begin
        bin_q[k] <= (done_i && code_i == k) ? CNT_W'(1) : '0;
      end
    end else if (done_i) begin
      for (int k = 0; k < lbp_pkg::NUM_BINS; k++) begin
        if (code_i == k) begin
          bin_q[k] <= bin_q[k] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      frame_q      <= '0;
      frame_done_q <= 1'b0;
    end else begin
      frame_done_q <= frame_end;
      if (clear_i) begin
        frame_q <= frame_end ? CNT_W'(1) : '0;
      end else if (frame_end) begin
        frame_q <= frame_q + 1'b1;
      end
    end
  end

  genvar g;
  for (g = 0; g < lbp_pkg::NUM_BINS; g++) begin : g_bins
    assign bins_o[g] = lbp_pkg::bin_cnt_t'(bin_q[g]);
  end

  assign frames_o     = lbp_pkg::bin_cnt_t'(frame_q);
  assign frame_done_o = frame_done_q;  // One-cycle pulse

endmodule

/* src/lbp_apb_regs.sv */
`timescale 1ns/1ps

module lbp_apb_regs (
  input  logic                                      clk,
  input  logic                                      rst_n_i,
  input  logic                                      psel_i,
  input  logic                                      penable_i,
  input  logic                                      pwrite_i,
  input  apb_pkg::apb_addr_t                        paddr_i,
  input  apb_pkg::apb_data_t                        pwdata_i,
  output apb_pkg::apb_data_t                        prdata_o,
  output logic                                      pready_o,
  output logic                                      pslverr_o,
  input  lbp_pkg::bin_cnt_t [lbp_pkg::NUM_BINS-1:0] bins_i,
  input  lbp_pkg::bin_cnt_t                         frames_i,
  input  logic                                      frame_done_i,
  output logic                                      enable_o,
  output logic                                      clear_o,
  output logic                                      irq_o
);

  apb_pkg::apb_addr_t bin_off;
  logic [3:0]         bin_idx;
  logic               hit_ctrl;
  logic               hit_status;
  logic               hit_frames;
  logic               hit_bin;
  logic               mapped;
  logic               read_only;
  logic               access;
  logic               wr_en;
  logic               enable_q;
  logic               clear_q;
  logic               status_q;

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  // Address decode
  assign bin_off    = paddr_i - apb_pkg::ADDR_BIN_BASE;
  assign bin_idx    = bin_off[5:2];
  assign hit_ctrl   = (paddr_i == apb_pkg::ADDR_CTRL);
  assign hit_status = (paddr_i == apb_pkg::ADDR_STATUS);
  assign hit_frames = (paddr_i == apb_pkg::ADDR_FRAMES);
  assign hit_bin    = (paddr_i >= apb_pkg::ADDR_BIN_BASE) && (bin_off[1:0] == 2'b00) &&
                      (bin_off[11:2] < lbp_pkg::NUM_BINS);

  assign mapped    = hit_ctrl | hit_status | hit_frames | hit_bin;
  assign read_only = hit_frames | hit_bin;

  // Zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~mapped | (pwrite_i & read_only));

  always_comb begin
    prdata_o = '0;
    if (hit_ctrl) begin
      prdata_o[apb_pkg::CTRL_ENABLE_BIT] = enable_q;
    end else if (hit_status) begin
      prdata_o[apb_pkg::STATUS_FRAME_DONE_BIT] = status_q;
    end else if (hit_frames) begin
      prdata_o = frames_i;
    end else if (hit_bin) begin
      prdata_o = bins_i[bin_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      clear_q  <= 1'b0;
      status_q <= 1'b0;
    end else begin
      clear_q <= wr_en & hit_ctrl & pwdata_i[apb_pkg::CTRL_CLEAR_BIT];
      if (wr_en && hit_ctrl) begin
        enable_q <= pwdata_i[apb_pkg::CTRL_ENABLE_BIT];
      end
      // New frame end wins over a W1C in the same cycle
      if (frame_done_i) begin
        status_q <= 1'b1;
      end else if (wr_en && hit_status && pwdata_i[apb_pkg::STATUS_FRAME_DONE_BIT]) begin
        status_q <= 1'b0;
      end
    end
  end

  assign enable_o = enable_q;
  assign clear_o  = clear_q;
  assign irq_o    = status_q;

endmodule

/* src/lbp_top.sv */
`timescale 1ns/1ps

module lbp_top #(
  parameter int PIX_W = 8,
  parameter int CNT_W = 32
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              win_valid_i,
  input  logic                              win_last_i,
  input  logic [PIX_W-1:0]                  center_i,
  input  logic [lbp_pkg::NUM_NBR*PIX_W-1:0] nbr_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  apb_pkg::apb_addr_t                paddr_i,
  input  apb_pkg::apb_data_t                pwdata_i,
  output apb_pkg::apb_data_t                prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  output logic                              irq_o
);

  lbp_pkg::pattern_t                        thr_pattern;
  logic                                     thr_done;
  logic                                     thr_last;
  lbp_pkg::code_t                           map_code;
  logic                                     map_done;
  logic                                     map_last;
  lbp_pkg::bin_cnt_t [lbp_pkg::NUM_BINS-1:0] hist_bins;
  lbp_pkg::bin_cnt_t                        hist_frames;
  logic                                     hist_frame_done;
  logic                                     ctrl_enable;
  logic                                     ctrl_clear;

  lbp_threshold #(
    .PIX_W(PIX_W)
  ) u_threshold (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .enable_i       (ctrl_enable),
    .win_valid_i    (win_valid_i),
    .win_last_i     (win_last_i),
    .center_i       (center_i),
    .nbr_i          (nbr_i),
    .pattern_o      (thr_pattern),
    .done_o         (thr_done),
    .progress_done_o(thr_last)
  );

  riu2_mapping u_riu2 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .done_i         (thr_done),
    .progress_done_i(thr_last),
    .pattern_i      (thr_pattern),
    .data_o         (map_code),
    .done_o         (map_done),
    .progress_done_o(map_last)
  );

  lbp_histogram #(
    .CNT_W(CNT_W)
  ) u_histogram (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .clear_i        (ctrl_clear),
    .done_i         (map_done),
    .progress_done_i(map_last),
    .code_i         (map_code),
    .bins_o         (hist_bins),
    .frames_o       (hist_frames),
    .frame_done_o   (hist_frame_done)
  );

  lbp_apb_regs u_regs (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .bins_i      (hist_bins),
    .frames_i    (hist_frames),
    .frame_done_i(hist_frame_done),
    .enable_o    (ctrl_enable),
    .clear_o     (ctrl_clear),
    .irq_o       (irq_o)
  );

endmodule

/* dv/lbp_tb.sv */
`timescale 1ns/1ps

module lbp_tb;

  localparam int PIX_W   = 8;
  localparam int CNT_W   = 32;
  localparam int NBR_W   = lbp_pkg::NUM_NBR * PIX_W;
  localparam int TIMEOUT = 50;  // Cycles allowed per wait
  localparam int SEED    = 32'h0369_ef35;

  logic               clk;
  logic               rst_n;
  logic               win_valid;
  logic               win_last;
  logic [PIX_W-1:0]   center;
  logic [NBR_W-1:0]   nbr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  apb_pkg::apb_addr_t paddr;
  apb_pkg::apb_data_t pwdata;
  apb_pkg::apb_data_t prdata;
  logic               pready;
  logic               pslverr;
  logic               irq;

  int   model_bins [lbp_pkg::NUM_BINS];
  int   model_frames;
  logic model_enable;
  logic model_clear;
  int   errors;
  int   tests;
  int   test_err_start;

  lbp_top #(
    .PIX_W(PIX_W),
    .CNT_W(CNT_W)
  ) i_dut (
    .clk        (clk),
    .rst_n_i    (rst_n),
    .win_valid_i(win_valid),
    .win_last_i (win_last),
    .center_i   (center),
    .nbr_i      (nbr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // riu2 code straight from the definition
  function automatic lbp_pkg::code_t riu2_ref(input logic [PIX_W-1:0] c,
                                              input logic [NBR_W-1:0] n);
    logic [7:0] bits;
    int         ones;
    int         flips;
    ones  = 0;
    flips = 0;
    for (int k = 0; k < 8; k++) begin
      bits[k] = (n[k*PIX_W +: PIX_W] >= c);
      ones += bits[k];
    end
    for (int k = 0; k < 8; k++) begin
      if (bits[k] != bits[(k + 7) % 8]) flips++;  // Circular neighbour
    end
    return (flips > 2) ? 4'd9 : 4'(ones);
  endfunction

  // Set bits become brighter neighbours
  function automatic logic [NBR_W-1:0] nbr_from_bits(input logic [7:0] bits,
                                                     input logic [PIX_W-1:0] c);
    logic [NBR_W-1:0] n;
    for (int k = 0; k < 8; k++) begin
      n[k*PIX_W +: PIX_W] = bits[k] ? c + 8'd20 : c - 8'd20;
    end
    return n;
  endfunction

  function automatic logic [7:0] arc_bits(input int len, input int start);
    logic [15:0] dbl;
    logic [7:0]  arc;
    arc = 8'((9'h1 << len) - 1);
    dbl = {arc, arc};
    return dbl[start +: 8];
  endfunction

  // Expected histogram fed from the stimulus
  always @(posedge clk) begin
    if (model_clear) begin
      for (int k = 0; k < lbp_pkg::NUM_BINS; k++) model_bins[k] = 0;
      model_frames = 0;
    end else if (rst_n && win_valid && model_enable) begin
      model_bins[riu2_ref(center, nbr)]++;
      if (win_last) model_frames++;
    end
  end

  task automatic abort_run(input string why);
    $display("ERROR t=%0t %s", $time, why);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic check_data(input string name, input apb_pkg::apb_data_t exp,
                            input apb_pkg::apb_data_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic apb_transfer(input logic wr, input apb_pkg::apb_addr_t addr,
                              input apb_pkg::apb_data_t wdata,
                              output apb_pkg::apb_data_t rdata, output logic err);
    int waits;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    #1;
    while (!pready) begin
      if (waits == TIMEOUT) abort_run($sformatf("no pready on APB access to 0x%03h", addr));
      @(negedge clk);
      #1;
      waits++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);  // Access phase ends on the posedge before this
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                           input logic exp_err);
    apb_pkg::apb_data_t unused;
    logic               err;
    apb_transfer(1'b1, addr, data, unused, err);
    check_bit($sformatf("pslverr_o write 0x%03h", addr), exp_err, err);
  endtask

  task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                          input logic exp_err);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    check_bit($sformatf("pslverr_o read 0x%03h", addr), exp_err, err);
  endtask

  task automatic read_check(input string name, input apb_pkg::apb_addr_t addr,
                            input apb_pkg::apb_data_t exp);
    apb_pkg::apb_data_t val;
    apb_read(addr, val, 1'b0);
    check_data(name, exp, val);
  endtask

  task automatic check_bins;
    for (int k = 0; k < lbp_pkg::NUM_BINS; k++) begin
      read_check($sformatf("bin[%0d]", k), apb_pkg::apb_addr_t'(apb_pkg::ADDR_BIN_BASE + 4*k),
                 apb_pkg::apb_data_t'(model_bins[k]));
    end
  endtask

  task automatic send_window(input logic [PIX_W-1:0] c, input logic [NBR_W-1:0] n,
                             input logic last);
    @(negedge clk);
    win_valid = 1'b1;
    win_last  = last;
    center    = c;
    nbr       = n;
  endtask

  task automatic idle_cycle;
    @(negedge clk);
    win_valid = 1'b0;
    win_last  = 1'b0;
  endtask

  task automatic wait_irq;
    int waits;
    waits = 0;
    while (irq !== 1'b1) begin
      if (waits == TIMEOUT) abort_run("irq_o never rose after the last window");
      @(negedge clk);
      waits++;
    end
  endtask

  task automatic wait_frames(input apb_pkg::apb_data_t exp);
    apb_pkg::apb_data_t val;
    int                 waits;
    waits = 0;
    apb_read(apb_pkg::ADDR_FRAMES, val, 1'b0);
    while (val !== exp) begin
      if (waits == TIMEOUT) abort_run("FRAMES never reached the expected count");
      apb_read(apb_pkg::ADDR_FRAMES, val, 1'b0);
      waits++;
    end
  endtask

  task automatic clear_histogram(input apb_pkg::apb_data_t ctrl);
    apb_write(apb_pkg::ADDR_CTRL, ctrl, 1'b0);
    model_clear = 1'b1;
    wait_frames(0);
    model_clear = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_err_start) ? "ok" : "mismatch");
    test_err_start = errors;
  endtask

  initial begin
    apb_pkg::apb_data_t val;
    logic [PIX_W-1:0]   rnd_c;
    logic [NBR_W-1:0]   rnd_nbr;
    void'($urandom(SEED));
    rst_n = 1'b0;
    win_valid = 1'b0;
    win_last = 1'b0;
    center = '0;
    nbr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    model_enable = 1'b0;
    model_clear = 1'b1;
    errors = 0;
    tests = 0;
    test_err_start = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    model_clear = 1'b0;

    read_check("CTRL", apb_pkg::ADDR_CTRL, 0);
    read_check("STATUS", apb_pkg::ADDR_STATUS, 0);
    read_check("FRAMES", apb_pkg::ADDR_FRAMES, 0);
    check_bins();
    check_bit("irq_o", 1'b0, irq);
    finish_test("reset values");

    apb_write(apb_pkg::ADDR_CTRL, 32'h1, 1'b0);
    model_enable = 1'b1;
    send_window(8'd100, nbr_from_bits(8'hFF, 8'd100), 1'b0);  // Code 8
    send_window(8'd100, nbr_from_bits(8'h00, 8'd100), 1'b0);  // Code 0
    send_window(8'd77, {8{8'd77}}, 1'b0);                    // Equal counts as set
    send_window(8'd100, nbr_from_bits(8'h07, 8'd100), 1'b0);
    send_window(8'd100, nbr_from_bits(8'hC1, 8'd100), 1'b0);  // Arc across bit 7
    send_window(8'd100, nbr_from_bits(8'h3E, 8'd100), 1'b0);
    send_window(8'd100, nbr_from_bits(8'h55, 8'd100), 1'b0);  // Code 9
    send_window(8'd100, nbr_from_bits(8'h5A, 8'd100), 1'b1);
    idle_cycle();
    wait_irq();
    check_bins();
    read_check("FRAMES", apb_pkg::ADDR_FRAMES, apb_pkg::apb_data_t'(model_frames));
    apb_write(apb_pkg::ADDR_STATUS, 32'h1, 1'b0);
    clear_histogram(32'h3);
    finish_test("directed windows");

    for (int i = 0; i < 300; i++) begin
      if ($urandom % 10 == 0) idle_cycle();
      if ($urandom % 2 == 0) begin
        rnd_c   = 8'($urandom);
        rnd_nbr = {$urandom, $urandom};
      end else begin
        rnd_c   = 8'(30 + $urandom % 196);
        rnd_nbr = nbr_from_bits(arc_bits($urandom % 9, $urandom % 8), rnd_c);
      end
      send_window(rnd_c, rnd_nbr, i == 299);
    end
    idle_cycle();
    wait_irq();
    check_bins();
    read_check("FRAMES", apb_pkg::ADDR_FRAMES, apb_pkg::apb_data_t'(model_frames));
    finish_test("random frame");

    check_bit("irq_o", 1'b1, irq);
    read_check("STATUS", apb_pkg::ADDR_STATUS, 1);
    apb_write(apb_pkg::ADDR_STATUS, 32'h1, 1'b0);
    read_check("STATUS", apb_pkg::ADDR_STATUS, 0);
    check_bit("irq_o", 1'b0, irq);
    finish_test("status and irq");

    apb_write(apb_pkg::ADDR_CTRL, 32'h0, 1'b0);
    model_enable = 1'b0;
    for (int i = 0; i < 20; i++) begin
      send_window(8'($urandom), {$urandom, $urandom}, i == 19);
    end
    idle_cycle();
    repeat (8) @(negedge clk);  // Longer than the 5-cycle pipeline
    check_bins();
    read_check("FRAMES", apb_pkg::ADDR_FRAMES, apb_pkg::apb_data_t'(model_frames));
    check_bit("irq_o", 1'b0, irq);
    clear_histogram(32'h2);
    check_bins();
    read_check("CTRL", apb_pkg::ADDR_CTRL, 0);
    finish_test("disable and clear");

    apb_write(apb_pkg::ADDR_CTRL, 32'h1, 1'b0);
    apb_read(12'h100, val, 1'b1);
    apb_write(12'h00C, 32'h0000_0000, 1'b1);  // Would drop enable if decoded as CTRL
    apb_write(apb_pkg::ADDR_BIN_BASE + 12'h008, 32'h1234, 1'b1);
    apb_write(apb_pkg::ADDR_FRAMES, 32'h5, 1'b1);
    apb_read(apb_pkg::apb_addr_t'(apb_pkg::ADDR_BIN_BASE + 4*lbp_pkg::NUM_BINS), val, 1'b1);
    read_check("CTRL", apb_pkg::ADDR_CTRL, 1);
    read_check("STATUS", apb_pkg::ADDR_STATUS, 0);
    read_check("FRAMES", apb_pkg::ADDR_FRAMES, apb_pkg::apb_data_t'(model_frames));
    check_bins();
    finish_test("bus errors");

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
src/lbp_pkg.sv
src/apb_pkg.sv
src/lbp_threshold.sv
src/riu2_mapping.sv
src/lbp_histogram.sv
src/lbp_apb_regs.sv
src/lbp_top.sv
dv/lbp_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module lbp_tb -o lbp_sim
./obj_dir/lbp_sim > sim.log
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
